// ==== hdl/spc_pkg.sv ====
// ====================================================================
// Types and sizes of the subroutine-return (SPC) stack.
// The stack control, the dual-port RAM, the APB block and the top
// level import this package with a wildcard import.
// ====================================================================

package spc_pkg;

   localparam int spc_depth_c  = 32;
   localparam int spc_addr_w_c = 5;
   localparam int spc_data_w_c = 19;

   typedef logic [spc_addr_w_c-1:0] spc_addr_t;
   typedef logic [spc_data_w_c-1:0] spc_entry_t;

   // one sequencer request per cycle.
   typedef struct packed {
      logic       push;
      logic       pop;
      spc_entry_t data;   // word to push.
   } spc_cmd_t;

   typedef struct packed {
      spc_addr_t  addr;
      spc_entry_t wdata;
      logic       wren;
      logic       rden;
   } spc_ram_port_t;

endpackage

// ==== hdl/apb_pkg.sv ====
// ====================================================================
// APB request and response types and the debug register map of the
// SPC stack. Used by the APB register block and the top level.
// ====================================================================

package apb_pkg;

   localparam int apb_addr_w_c = 8;
   localparam int apb_data_w_c = 32;

   typedef struct packed {
      logic                    psel;
      logic                    penable;
      logic                    pwrite;
      logic [apb_addr_w_c-1:0] paddr;
      logic [apb_data_w_c-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [apb_data_w_c-1:0] prdata;
      logic                    pready;
      logic                    pslverr;
   } apb_rsp_t;

   // register map.
   localparam logic [apb_addr_w_c-1:0] reg_ptr_c        = 8'h00;
   localparam logic [apb_addr_w_c-1:0] reg_flags_c      = 8'h04;
   localparam logic [apb_addr_w_c-1:0] reg_entry_base_c = 8'h80;  // entry i at base + 4*i.

endpackage

// ==== hdl/spc_dpram.sv ====
// ====================================================================
// 32x19 synchronous dual-port RAM holding the SPC stack entries.
// Port A belongs to the stack control and port B to the APB block.
// A port-A write wins over a port-B write; wr_b_ack reports when the
// port-B write is taken. Both read ports are registered.
// ====================================================================

`timescale 1ns/100ps

module spc_dpram
   import spc_pkg::*;
(
   input  logic          clk_a,
   input  logic          reset,
   input  spc_ram_port_t port_a,
   input  spc_ram_port_t port_b,
   output spc_entry_t    q_a,
   output spc_entry_t    q_b,
   output logic          wr_b_ack
);

   spc_entry_t mem [spc_depth_c];

   assign wr_b_ack = port_b.wren && !port_a.wren;  // b writes only when a is idle.

   always_ff @(posedge clk_a)
   begin
      if (port_a.wren)
         mem[port_a.addr] <= port_a.wdata;
      else if (port_b.wren)
         mem[port_b.addr] <= port_b.wdata;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (port_a.rden)
      begin
         if (wr_b_ack && port_b.addr == port_a.addr)
            q_a <= port_b.wdata;  // read new data on collision.
         else
            q_a <= mem[port_a.addr];
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (port_b.rden)
         q_b <= mem[port_b.addr];
   end

   // a refused port-B write is retried unchanged.
   a_wr_b_hold: assert property (@(posedge clk_a) disable iff (reset)
      port_b.wren && !wr_b_ack
      |=> port_b.wren && port_b.addr == $past(port_b.addr));

endmodule

// ==== hdl/spc_stack_ctl.sv ====
// ====================================================================
// Stack pointer and push/pop sequencing of the SPC stack.
// A push writes at ptr+1, a pop reads at ptr; the popped word comes
// back from the RAM one cycle later on spc_q. Overflow and underflow
// are sticky and cleared from the APB side. A pointer load from APB
// takes precedence over a push or pop in the same cycle.
// ====================================================================

`timescale 1ns/100ps

module spc_stack_ctl
   import spc_pkg::*;
(
   input  logic          clk_a,
   input  logic          reset,
   input  spc_cmd_t      spc_cmd,
   input  logic          ptr_load,
   input  spc_addr_t     ptr_wdata,
   input  logic [1:0]    flags_clr,
   output spc_ram_port_t port_a,
   input  spc_entry_t    q_a,
   output spc_entry_t    spc_q,
   output spc_addr_t     ptr,
   output logic [1:0]    flags
);

   logic       do_push;
   logic       do_pop;
   spc_addr_t  ptr_next;
   logic [1:0] flags_set;

   assign do_push = spc_cmd.push && !ptr_load;  // load wins.
   assign do_pop  = spc_cmd.pop && !ptr_load;

   assign ptr_next = spc_addr_t'(ptr + 1'b1);

   always_comb
   begin
      port_a.addr  = do_push ? ptr_next : ptr;
      port_a.wdata = spc_cmd.data;
      port_a.wren  = do_push;
      port_a.rden  = do_pop;
   end

   assign spc_q = q_a;  // ram output register holds last pop.

   // bit 0 overflow, bit 1 underflow.
   assign flags_set[0] = do_push && ptr == spc_addr_t'(spc_depth_c - 1);
   assign flags_set[1] = do_pop && ptr == '0;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         ptr <= spc_addr_t'(spc_depth_c - 1);  // empty.
      else if (ptr_load)
         ptr <= ptr_wdata;
      else if (do_push)
         ptr <= ptr_next;
      else if (do_pop)
         ptr <= spc_addr_t'(ptr - 1'b1);
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         flags <= 2'b00;
      else
         flags <= (flags & ~flags_clr) | flags_set;  // a new event beats a clear.
   end

   a_one_cmd: assert property (@(posedge clk_a) disable iff (reset)
      !(spc_cmd.push && spc_cmd.pop));

endmodule

// ==== hdl/spc_apb_regs.sv ====
// ====================================================================
// APB slave for debug access to the SPC stack.
// Serves the pointer and flags registers and a window onto every
// stack entry through port B of the RAM. Entry reads take one wait
// state; entry writes wait until the RAM accepts them.
// ====================================================================

`timescale 1ns/100ps

module spc_apb_regs
   import spc_pkg::*;
   import apb_pkg::*;
(
   input  logic          clk_a,
   input  logic          reset,
   input  apb_req_t      apb,
   output apb_rsp_t      apb_rsp,
   output spc_ram_port_t port_b,
   input  spc_entry_t    q_b,
   input  logic          wr_b_ack,
   input  spc_addr_t     ptr,
   input  logic [1:0]    flags,
   output logic          ptr_load,
   output spc_addr_t     ptr_wdata,
   output logic [1:0]    flags_clr
);

   typedef enum logic [1:0] {st_idle, st_access, st_rd_done} state_t;

   state_t                  state;
   logic                    wr_stalled;
   logic [apb_addr_w_c-1:0] entry_off;
   logic                    hit_ptr;
   logic                    hit_flags;
   logic                    hit_entry;
   logic                    in_access;
   logic                    entry_rd;
   logic                    entry_wr;
   logic                    ready;

   assign entry_off = apb.paddr - reg_entry_base_c;
   assign hit_ptr   = apb.paddr == reg_ptr_c;
   assign hit_flags = apb.paddr == reg_flags_c;
   assign hit_entry = apb.paddr >= reg_entry_base_c
                      && entry_off < apb_addr_w_c'(spc_depth_c * 4)
                      && entry_off[1:0] == 2'b00;

   assign in_access = state == st_access && apb.psel && apb.penable;
   assign entry_rd  = in_access && hit_entry && !apb.pwrite;
   assign entry_wr  = in_access && hit_entry && apb.pwrite;

   assign port_b = '{addr:  entry_off[spc_addr_w_c+1:2],
                     wdata: spc_entry_t'(apb.pwdata),
                     wren:  entry_wr,    // held until wr_b_ack.
                     rden:  entry_rd};

   assign ptr_load  = in_access && apb.pwrite && hit_ptr;
   assign ptr_wdata = spc_addr_t'(apb.pwdata);
   assign flags_clr = (in_access && apb.pwrite && hit_flags) ? apb.pwdata[1:0] : 2'b00;

   assign ready = (in_access && !entry_rd && !(entry_wr && !wr_b_ack))
                  || state == st_rd_done;

   always_comb
   begin
      apb_rsp = '0;
      apb_rsp.pready  = ready;
      apb_rsp.pslverr = in_access && ready
                        && (!(hit_ptr || hit_flags || hit_entry) || (entry_wr && wr_stalled));
      if (state == st_rd_done)
         apb_rsp.prdata = apb_data_w_c'(q_b);
      else if (hit_ptr)
         apb_rsp.prdata = apb_data_w_c'(ptr);
      else if (hit_flags)
         apb_rsp.prdata = apb_data_w_c'(flags);
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         state <= st_idle;
      else
      begin
         case (state)
            st_idle:    if (apb.psel && !apb.penable) state <= st_access;
            st_access:  if (entry_rd) state <= st_rd_done;
                        else if (ready) state <= st_idle;
            st_rd_done: state <= st_idle;
            default:    state <= st_idle;
         endcase
      end
   end

   // write had to wait behind stack traffic.
   always_ff @(posedge clk_a)
   begin
      if (reset || state == st_idle)
         wr_stalled <= 1'b0;
      else if (entry_wr && !wr_b_ack)
         wr_stalled <= 1'b1;
   end

   a_req_stable: assert property (@(posedge clk_a) disable iff (reset)
      apb.psel && apb.penable && !apb_rsp.pready |=> $stable(apb));

endmodule

// ==== hdl/spc_top.sv ====
// ====================================================================
// Top level of the SPC return stack.
// The sequencer pushes and pops through spc_cmd and sees popped words
// on spc_q; a debugger inspects and edits the stack over APB.
// ====================================================================

`timescale 1ns/100ps

module spc_top
   import spc_pkg::*;
   import apb_pkg::*;
(
   input  logic       clk_a,
   input  logic       reset,
   input  spc_cmd_t   spc_cmd,
   output spc_entry_t spc_q,
   input  apb_req_t   apb,
   output apb_rsp_t   apb_rsp
);

   spc_ram_port_t port_a;
   spc_ram_port_t port_b;
   spc_entry_t    q_a;
   spc_entry_t    q_b;
   logic          wr_b_ack;
   logic          ptr_load;
   spc_addr_t     ptr_wdata;
   spc_addr_t     ptr;
   logic [1:0]    flags_clr;
   logic [1:0]    flags;

   spc_stack_ctl u_stack_ctl (
      .clk_a(clk_a), .reset(reset), .spc_cmd(spc_cmd),
      .ptr_load(ptr_load), .ptr_wdata(ptr_wdata), .flags_clr(flags_clr),
      .port_a(port_a), .q_a(q_a), .spc_q(spc_q), .ptr(ptr), .flags(flags)
   );

   spc_dpram u_dpram (
      .clk_a(clk_a), .reset(reset), .port_a(port_a), .port_b(port_b),
      .q_a(q_a), .q_b(q_b), .wr_b_ack(wr_b_ack)
   );

   spc_apb_regs u_apb_regs (
      .clk_a(clk_a), .reset(reset), .apb(apb), .apb_rsp(apb_rsp),
      .port_b(port_b), .q_b(q_b), .wr_b_ack(wr_b_ack), .ptr(ptr), .flags(flags),
      .ptr_load(ptr_load), .ptr_wdata(ptr_wdata), .flags_clr(flags_clr)
   );

endmodule

// ==== test/tb_spc_top.sv ====
// ====================================================================
// Testbench for the SPC return stack top level.
// Drives push and pop commands and APB debug transfers, runs a
// reference model of the stack and compares popped words and APB
// read data with it. Prints one line per test and a summary.
// ====================================================================

`timescale 1ns/100ps

module tb_spc_top
   import spc_pkg::*;
   import apb_pkg::*;
();

   localparam int clk_period_c    = 100;
   localparam int test_cycles_c   = 40 + 70 + 180 + 25 + 30 + 20;  // per-test lengths.
   localparam int margin_cycles_c = 200;
   localparam int apb_wait_max_c  = 64;

   logic       clk_a = 1'b0;
   logic       reset;
   spc_cmd_t   spc_cmd;
   spc_entry_t spc_q;
   apb_req_t   apb;
   apb_rsp_t   apb_rsp;

   logic [31:0] lfsr;
   spc_entry_t  m_mem [spc_depth_c];
   spc_addr_t   m_ptr = spc_addr_t'(spc_depth_c - 1);  // empty.
   logic [1:0]  m_flags = 2'b00;
   logic        m_popped = 1'b0;
   spc_entry_t  exp_q = '0;
   logic        pop_pending = 1'b0;
   logic [31:0] exp_rd = '0;
   logic        rd_armed = 1'b0;
   int          errors = 0;
   int          mon_errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          failed = 0;
   int          err_mark = 0;

   spc_top DUT (
      .clk_a(clk_a), .reset(reset), .spc_cmd(spc_cmd), .spc_q(spc_q),
      .apb(apb), .apb_rsp(apb_rsp)
   );

   always #(clk_period_c / 2) clk_a = ~clk_a;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;  // one step per bit.
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic is_entry(input logic [7:0] a);
      return a >= reg_entry_base_c && a[1:0] == 2'b00;
   endfunction

   function automatic spc_addr_t entry_idx(input logic [7:0] a);
      logic [7:0] off;
      off = a - reg_entry_base_c;
      return off[6:2];
   endfunction

   function automatic logic [7:0] entry_addr(input spc_addr_t i);
      return reg_entry_base_c + {1'b0, i, 2'b00};
   endfunction

   // one clock of the stack; returns the word the last pop read.
   function automatic spc_entry_t model_step(input spc_cmd_t cmd, input apb_req_t req,
                                             input logic done);
      logic       wr;
      logic       ld;
      logic [1:0] clr;
      logic [1:0] set;
      spc_entry_t q;
      wr  = done && req.pwrite;
      ld  = wr && req.paddr == reg_ptr_c;
      clr = (wr && req.paddr == reg_flags_c) ? req.pwdata[1:0] : 2'b00;
      set = 2'b00;
      q   = exp_q;
      m_popped = 1'b0;
      if (wr && is_entry(req.paddr))
         m_mem[entry_idx(req.paddr)] = req.pwdata[spc_data_w_c-1:0];  // before a pop reads.
      if (ld)
         m_ptr = req.pwdata[spc_addr_w_c-1:0];
      else if (cmd.push)
      begin
         set[0] = m_ptr == spc_addr_t'(spc_depth_c - 1);
         m_ptr = m_ptr + 5'd1;
         m_mem[m_ptr] = cmd.data;
      end
      else if (cmd.pop)
      begin
         set[1] = m_ptr == 5'd0;
         q = m_mem[m_ptr];
         m_ptr = m_ptr - 5'd1;
         m_popped = 1'b1;
      end
      m_flags = (m_flags & ~clr) | set;
      return q;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act, inout int count);
      count++;
      $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
   endtask

   task automatic stack_cmd(input logic push, input logic pop, input spc_entry_t data);
      @(posedge clk_a);
      spc_cmd <= '{push: push, pop: pop, data: data};
   endtask

   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int waits;
      waits = 0;
      @(posedge clk_a);
      apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(posedge clk_a);
      apb.penable <= 1'b1;
      @(negedge clk_a);
      while (!apb_rsp.pready && waits < apb_wait_max_c)
      begin
         @(negedge clk_a);
         waits++;
      end
      if (!apb_rsp.pready)
      begin
         errors++;
         $display("APB transfer to address %h never completed", addr);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk_a);
      apb <= '0;
   endtask

   task automatic finish_test(input string name);
      repeat (2) @(negedge clk_a);  // let the last compare run.
      tests++;
      if (errors + mon_errors == err_mark)
         $display("test %0d %s: ok", tests, name);
      else
      begin
         failed++;
         $display("test %0d %s: %0d errors", tests, name, errors + mon_errors - err_mark);
      end
      err_mark = errors + mon_errors;
   endtask

   // compare process, sampling at the falling edge.
   always @(negedge clk_a)
   begin
      logic        done;
      logic [31:0] exp;
      if (!reset)
      begin
         done = apb.psel && apb.penable && apb_rsp.pready;
         if (pop_pending)
         begin
            checks++;
            if (spc_q !== exp_q)
               report_mismatch("spc_q", 32'(exp_q), 32'(spc_q), mon_errors);
         end
         if (apb.psel && apb.penable && !apb.pwrite && is_entry(apb.paddr) && !rd_armed)
         begin
            exp_rd = 32'(m_mem[entry_idx(apb.paddr)]);  // ram read at this edge.
            rd_armed = 1'b1;
         end
         if (done && !apb.pwrite
             && (is_entry(apb.paddr) || apb.paddr == reg_ptr_c || apb.paddr == reg_flags_c))
         begin
            exp = is_entry(apb.paddr) ? exp_rd
                : (apb.paddr == reg_ptr_c) ? 32'(m_ptr) : 32'(m_flags);
            checks++;
            if (apb_rsp.prdata !== exp)
               report_mismatch("prdata", exp, apb_rsp.prdata, mon_errors);
         end
         if (done)
            rd_armed = 1'b0;
         exp_q = model_step(spc_cmd, apb, done);
         pop_pending = m_popped;
      end
   end

   initial
   begin
      #((test_cycles_c + margin_cycles_c) * clk_period_c);
      $display("watchdog: run did not end within %0d clock cycles",
               test_cycles_c + margin_cycles_c);
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      logic [31:0] rd;
      logic        err;
      spc_addr_t   idx;
      spc_entry_t  word;
      time         burst_end;
      time         wr_end;
      lfsr    = 32'hc479;
      reset   = 1'b1;
      spc_cmd = '0;
      apb     = '0;
      repeat (2) @(posedge clk_a);
      reset <= 1'b0;

      apb_xfer(1'b0, reg_ptr_c, '0, rd, err);
      if (rd !== 32'd31)
         report_mismatch("ptr", 32'd31, rd, errors);
      apb_xfer(1'b0, reg_flags_c, '0, rd, err);
      if (rd !== 32'd0)
         report_mismatch("flags", 32'd0, rd, errors);
      for (int i = 0; i < 10; i++)
         stack_cmd(1'b1, 1'b0, spc_entry_t'(rand_bits(spc_data_w_c)));
      for (int i = 0; i < 10; i++)
         stack_cmd(1'b0, 1'b1, '0);
      stack_cmd(1'b0, 1'b0, '0);
      finish_test("reset and lifo");

      apb_xfer(1'b1, reg_flags_c, 32'h3, rd, err);
      for (int i = 0; i < 33; i++)
         stack_cmd(1'b1, 1'b0, spc_entry_t'(rand_bits(spc_data_w_c)));
      stack_cmd(1'b0, 1'b0, '0);
      apb_xfer(1'b0, reg_ptr_c, '0, rd, err);
      apb_xfer(1'b0, reg_flags_c, '0, rd, err);
      if (rd[0] !== 1'b1)
         report_mismatch("flags[0]", 32'd1, 32'(rd[0]), errors);
      apb_xfer(1'b1, reg_flags_c, 32'h1, rd, err);
      apb_xfer(1'b0, reg_flags_c, '0, rd, err);
      if (rd[0] !== 1'b0)
         report_mismatch("flags[0]", 32'd0, 32'(rd[0]), errors);
      stack_cmd(1'b0, 1'b1, '0);  // ptr is 0 here.
      stack_cmd(1'b0, 1'b1, '0);
      stack_cmd(1'b0, 1'b0, '0);
      apb_xfer(1'b0, reg_flags_c, '0, rd, err);
      if (rd[1] !== 1'b1)
         report_mismatch("flags[1]", 32'd1, 32'(rd[1]), errors);
      finish_test("wrap and flags");

      for (int i = 0; i < 4; i++)
         stack_cmd(1'b1, 1'b0, spc_entry_t'(rand_bits(spc_data_w_c)));
      stack_cmd(1'b0, 1'b0, '0);
      for (int i = 0; i < spc_depth_c; i++)
         apb_xfer(1'b0, reg_entry_base_c + 8'(4 * i), '0, rd, err);
      apb_xfer(1'b0, 8'h40, '0, rd, err);
      if (err !== 1'b1)
         report_mismatch("pslverr", 32'd1, 32'(err), errors);
      finish_test("entry window");

      idx = m_ptr;
      apb_xfer(1'b1, entry_addr(idx), rand_bits(spc_data_w_c), rd, err);
      if (err !== 1'b0)
         report_mismatch("pslverr", 32'd0, 32'(err), errors);
      stack_cmd(1'b0, 1'b1, '0);
      stack_cmd(1'b0, 1'b0, '0);
      idx  = m_ptr;
      word = spc_entry_t'(rand_bits(spc_data_w_c));
      fork
         apb_xfer(1'b1, entry_addr(idx), 32'(word), rd, err);
         begin
            @(posedge clk_a);
            stack_cmd(1'b0, 1'b1, '0);  // lands in the first access cycle.
            stack_cmd(1'b0, 1'b0, '0);
         end
      join
      finish_test("write then pop");

      idx  = m_ptr + 5'd3;
      word = spc_entry_t'(rand_bits(spc_data_w_c));
      fork
         begin
            for (int i = 0; i < 8; i++)
               stack_cmd(1'b1, 1'b0, spc_entry_t'(rand_bits(spc_data_w_c)));
            stack_cmd(1'b0, 1'b0, '0);
            burst_end = $time;
         end
         begin
            @(posedge clk_a);
            apb_xfer(1'b1, entry_addr(idx), 32'(word), rd, err);
            wr_end = $time;
         end
      join
      if (wr_end <= burst_end)
      begin
         errors++;
         $display("APB entry write finished before the push burst ended");
      end
      if (err !== 1'b1)
         report_mismatch("pslverr", 32'd1, 32'(err), errors);
      apb_xfer(1'b0, entry_addr(idx), '0, rd, err);
      if (rd !== 32'(word))
         report_mismatch("prdata", 32'(word), rd, errors);
      apb_xfer(1'b0, entry_addr(idx + 5'd1), '0, rd, err);
      finish_test("write behind pushes");

      word = spc_entry_t'(rand_bits(spc_data_w_c));
      apb_xfer(1'b1, reg_ptr_c, 32'd12, rd, err);
      stack_cmd(1'b1, 1'b0, word);
      stack_cmd(1'b0, 1'b0, '0);
      apb_xfer(1'b0, entry_addr(5'd13), '0, rd, err);
      if (rd !== 32'(word))
         report_mismatch("prdata", 32'(word), rd, errors);
      apb_xfer(1'b0, reg_ptr_c, '0, rd, err);
      finish_test("pointer load");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed, checks, errors + mon_errors);
      if (errors + mon_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== list.f ====
hdl/spc_pkg.sv
hdl/apb_pkg.sv
hdl/spc_dpram.sv
hdl/spc_stack_ctl.sv
hdl/spc_apb_regs.sv
hdl/spc_top.sv
test/tb_spc_top.sv

// ==== Makefile ====
# Verilator build and run for the SPC return stack testbench.
# Override any variable on the command line, e.g. make run TOP=tb_spc_top

VERILATOR ?= verilator
TOP       ?= tb_spc_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_LINE ?= STATUS: PASS

SRCS := $(shell grep '\.sv$$' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status of the pipe is the status of grep
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q '^$(PASS_LINE)$$'

clean:
	rm -rf $(OBJ_DIR)
